//--- verilog.f
dbg_pkg.sv
instr_fetch.sv
pipe_stage.sv
retire_unit.sv
debug_unit.sv
debug_core_top.sv
tb_debug_core_chk.sv
tb_debug_core.sv

//--- tb_debug_core.sv
`timescale 1ns/1ns

module tb_debug_core
    import dbg_pkg::*;
();

    localparam int NS  = 3; // pipeline stages
    localparam int NR  = 8;
    localparam int NB  = 4 * (NS + NR + 2); // dump bytes
    localparam int NT  = 5;
    localparam int TMO = 200;

    logic       clk;
    logic       reset;
    logic       rx_valid;
    logic [7:0] rx_data;
    logic       tx_start;
    logic [7:0] tx_data;
    logic       tx_done;
    dbg_state_t state;

    word_t       tprog [NT][6]; // halt terminated programs
    int          tsteps [NT];   // 0 means continuous
    logic [7:0]  exp_bytes [NB];
    logic [31:0] lfsr;
    int          checks;
    int          errors;
    int          timeouts;

    debug_core_top #(.NUM_STAGES(NS), .NUM_REGS(NR), .PROG_DEPTH(64)) DUT (.*);

    always #4 clk = ~clk;

    function automatic word_t instr(input logic [5:0] op, input int rd, input int imm);
        return {op, 5'(rd), 5'd0, 16'(imm)};
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32 22 2 1
    endfunction

    task automatic finish_run;
        int asrt_fails;
        asrt_fails = DUT.u_debug.u_chk.fail_cnt;
        $display("checks %0d, value errors %0d, timeouts %0d, assertion failures %0d",
                 checks, errors, timeouts, asrt_fails);
        if (errors + timeouts + asrt_fails == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("error %s: expected %0h, actual %0h", name, exp, act);
        end
    endtask

    task automatic give_up(input string what);
        timeouts++;
        $display("timed out waiting for %s", what);
        finish_run();
    endtask

    task automatic wait_state(input dbg_state_t s);
        int n;
        n = 0;
        while (state !== s && n < TMO) begin
            @(negedge clk);
            n++;
        end
        if (state !== s) begin
            give_up(s.name());
        end
    endtask

    ////////////////////////////////
    // host side of the byte link
    ////////////////////////////////
    task automatic send_byte(input logic [7:0] b);
        rx_data  = b;
        rx_valid = 1'b1;
        @(negedge clk);
        rx_valid = 1'b0;
        @(negedge clk); // idle gap
    endtask

    task automatic load_program(input int t);
        bit last;
        last = 1'b0;
        send_byte(CMD_REPROGRAM);
        send_byte(CMD_START);
        for (int i = 0; i < 6 && !last; i++) begin
            for (int b = 0; b < 4; b++) begin
                send_byte(tprog[t][i][8*b +: 8]); // lsb first
            end
            last = (tprog[t][i][OPC_MSB:OPC_LSB] == OP_HALT);
        end
        wait_state(ST_WAITING);
    endtask

    // model of the dump after k advances
    task automatic build_expected(input int t, inout int k);
        word_t w [NS + NR + 2];
        word_t regs [NR];
        word_t ins;
        int    h;
        h = 5;
        for (int i = 5; i >= 0; i--) begin
            if (tprog[t][i][OPC_MSB:OPC_LSB] == OP_HALT) begin
                h = i;
            end
        end
        if (k < 0) begin
            k = h + NS + 1; // run until halt retires
        end
        w[0] = (k <= h) ? k : h + 1;
        for (int j = 1; j <= NS; j++) begin
            w[j] = (k - j >= 0 && k - j <= h) ? tprog[t][k-j] : '0;
        end
        w[NS+1] = k;
        for (int r = 0; r < NR; r++) begin
            regs[r] = '0;
        end
        for (int i = 0; i <= h && i < k - NS; i++) begin
            ins = tprog[t][i];
            if (int'(ins[RD_MSB:RD_LSB]) < NR) begin
                if (ins[OPC_MSB:OPC_LSB] == OP_LOAD_IMM) begin
                    regs[ins[RD_MSB:RD_LSB]] = {16'd0, ins[IMM_MSB:IMM_LSB]};
                end else if (ins[OPC_MSB:OPC_LSB] == OP_ADD_IMM) begin
                    regs[ins[RD_MSB:RD_LSB]] += {16'd0, ins[IMM_MSB:IMM_LSB]};
                end
            end
        end
        for (int r = 0; r < NR; r++) begin
            w[NS+2+r] = regs[r];
        end
        for (int b = 0; b < NB; b++) begin
            exp_bytes[b] = w[b/4][8*(b%4) +: 8];
        end
    endtask

    task automatic recv_check(input int t, input int k);
        logic [1:0] d;
        int         n;
        build_expected(t, k);
        for (int b = 0; b < NB; b++) begin
            n = 0;
            while (!tx_start && n < TMO) begin
                @(negedge clk);
                n++;
            end
            if (!tx_start) begin
                give_up("tx_start");
            end
            check_value($sformatf("test %0d advance %0d byte %0d", t, k, b),
                        exp_bytes[b], tx_data);
            for (int i = 0; i < 2; i++) begin
                lfsr = lfsr_next(lfsr);
                d[i] = lfsr[0];
            end
            repeat (d) @(negedge clk); // host reply delay
            tx_done = 1'b1;
            @(negedge clk);
            tx_done = 1'b0;
        end
    endtask

    initial begin
        clk      = 1'b0;
        reset    = 1'b1;
        rx_valid = 1'b0;
        rx_data  = '0;
        tx_done  = 1'b0;
        lfsr     = 32'h086dc952;
        checks   = 0;
        errors   = 0;
        timeouts = 0;

        tprog[0] = '{instr(OP_LOAD_IMM, 1, 5), instr(OP_LOAD_IMM, 2, 7),
                     instr(OP_ADD_IMM, 1, 3), instr(OP_HALT, 0, 0), '0, '0};
        tprog[1] = '{instr(OP_LOAD_IMM, 3, 'h10), instr(OP_ADD_IMM, 3, 1),
                     instr(6'd0, 4, 9), instr(OP_LOAD_IMM, 7, 'habcd),
                     instr(OP_HALT, 0, 0), '0};
        tprog[2] = '{instr(OP_LOAD_IMM, 0, 1), instr(OP_ADD_IMM, 0, 2),
                     instr(OP_ADD_IMM, 0, 4), instr(OP_ADD_IMM, 6, 'hffff),
                     instr(OP_HALT, 0, 0), '0};
        tprog[3] = '{instr(OP_LOAD_IMM, 1, 'h1234), instr(OP_ADD_IMM, 5, 'h22),
                     instr(OP_LOAD_IMM, 9, 5), instr(OP_ADD_IMM, 5, 'h22),
                     instr(OP_HALT, 0, 0), '0};
        tprog[4] = tprog[0]; // same run again with other tx_done delays
        tsteps   = '{0, 8, 5, 0, 0};

        repeat (16) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_value("reset state", ST_WAITING, state);
        check_value("reset tx_start", 1'b0, tx_start);

        send_byte(8'h77);
        check_value("stray byte 77", ST_WAITING, state);
        send_byte(CMD_STEP);
        check_value("stray step", ST_WAITING, state);

        for (int t = 0; t < NT; t++) begin
            load_program(t);
            if (tsteps[t] == 0) begin
                send_byte(CMD_CONTINUOUS);
                recv_check(t, -1);
                wait_state(ST_WAITING);
            end else begin
                send_byte(CMD_STEP_MODE);
                wait_state(ST_STEP_MODE);
                for (int k = 1; k <= tsteps[t]; k++) begin
                    send_byte(CMD_STEP);
                    recv_check(t, k);
                end
            end
        end
        finish_run();
    end

endmodule

//--- tb_debug_core_chk.sv
`timescale 1ns/1ns

module debug_unit_chk
    import dbg_pkg::*;
(
    input logic       clk,
    input logic       reset,
    input dbg_state_t state,
    input logic       tx_start,
    input logic       prog_we,
    input logic       core_reset,
    input logic       step_en,
    input word_t      pc,
    input logic       halted
);

    int fail_cnt = 0; // read by the testbench at the end

    ////////////////////////////////
    // controller rules
    ////////////////////////////////
    tx_only_sending: assert property (@(posedge clk) disable iff (reset)
        tx_start |-> state == ST_SENDING)
        else begin
            $error("tx_start high outside sending");
            fail_cnt++;
        end

    we_only_programming: assert property (@(posedge clk) disable iff (reset)
        prog_we |-> state == ST_PROGRAMMING)
        else begin
            $error("prog_we high outside programming");
            fail_cnt++;
        end

    // one cycle into waiting the core must really be cleared and stopped
    core_held_waiting: assert property (@(posedge clk) disable iff (reset)
        (state == ST_WAITING) && ($past(state) == ST_WAITING)
            |-> core_reset && !step_en && (pc == '0) && !halted)
        else begin
            $error("core not held in reset while waiting");
            fail_cnt++;
        end

endmodule

bind debug_unit debug_unit_chk u_chk (
    .clk        (clk),
    .reset      (reset),
    .state      (state),
    .tx_start   (tx_start),
    .prog_we    (prog_we),
    .core_reset (core_reset),
    .step_en    (step_en),
    .pc         (pc),
    .halted     (halted)
);

//--- debug_core_top.sv
`timescale 1ns/1ns

module debug_core_top
    import dbg_pkg::*;
#(
    parameter int NUM_STAGES = 3,
    parameter int NUM_REGS   = 8,
    parameter int PROG_DEPTH = 64
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       rx_valid,
    input  logic [7:0] rx_data,
    output logic       tx_start,
    output logic [7:0] tx_data,
    input  logic       tx_done,
    output dbg_state_t state
);

    logic                          prog_we;
    logic [$clog2(PROG_DEPTH)-1:0] prog_addr;
    word_t                         prog_data;
    logic                          core_reset;
    logic                          step_en;
    stage_t                        fetch_out;
    word_t                         pc;
    stage_t                        snap [NUM_STAGES]; // stage 1 at index 0
    logic                          halted;
    logic [$clog2(NUM_REGS)-1:0]   reg_addr;
    word_t                         reg_data;

    debug_unit #(
        .NUM_STAGES (NUM_STAGES),
        .NUM_REGS   (NUM_REGS),
        .PROG_DEPTH (PROG_DEPTH)
    ) u_debug (
        .clk        (clk),
        .reset      (reset),
        .rx_valid   (rx_valid),
        .rx_data    (rx_data),
        .tx_done    (tx_done),
        .snapshots  (snap),
        .pc         (pc),
        .halted     (halted),
        .reg_data   (reg_data),
        .tx_start   (tx_start),
        .tx_data    (tx_data),
        .state      (state),
        .prog_we    (prog_we),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .core_reset (core_reset),
        .step_en    (step_en),
        .reg_addr   (reg_addr)
    );

    instr_fetch #(
        .PROG_DEPTH (PROG_DEPTH)
    ) u_fetch (
        .clk        (clk),
        .reset      (reset),
        .core_reset (core_reset),
        .step_en    (step_en),
        .prog_we    (prog_we),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .fetch_out  (fetch_out),
        .pc         (pc)
    );

    ////////////////////////////////
    // latch chain
    ////////////////////////////////
    for (genvar g = 0; g < NUM_STAGES; g++) begin : g_stage
        stage_t stage_in;

        if (g == 0) begin : g_first
            assign stage_in = fetch_out;
        end else begin : g_next
            assign stage_in = snap[g-1];
        end

        pipe_stage u_stage (
            .clk        (clk),
            .reset      (reset),
            .core_reset (core_reset),
            .step_en    (step_en),
            .stage_in   (stage_in),
            .stage_out  (snap[g])
        );
    end

    retire_unit #(
        .NUM_REGS (NUM_REGS)
    ) u_retire (
        .clk        (clk),
        .reset      (reset),
        .core_reset (core_reset),
        .step_en    (step_en),
        .retire_in  (snap[NUM_STAGES-1]), // last stage drains here
        .reg_addr   (reg_addr),
        .reg_data   (reg_data),
        .halted     (halted)
    );

endmodule

//--- debug_unit.sv
`timescale 1ns/1ns

module debug_unit
    import dbg_pkg::*;
#(
    parameter int NUM_STAGES = 3,
    parameter int NUM_REGS   = 8,
    parameter int PROG_DEPTH = 64
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          rx_valid,
    input  logic [7:0]                    rx_data,
    input  logic                          tx_done,
    input  stage_t                        snapshots [NUM_STAGES],
    input  word_t                         pc,
    input  logic                          halted,
    input  word_t                         reg_data,
    output logic                          tx_start,
    output logic [7:0]                    tx_data,
    output dbg_state_t                    state,
    output logic                          prog_we,
    output logic [$clog2(PROG_DEPTH)-1:0] prog_addr,
    output word_t                         prog_data,
    output logic                          core_reset,
    output logic                          step_en,
    output logic [$clog2(NUM_REGS)-1:0]   reg_addr
);

    localparam int RAW       = $clog2(NUM_REGS);
    localparam int NUM_WORDS = NUM_STAGES + NUM_REGS + 2; // pc, stages, cycles, regs
    localparam int WIW       = $clog2(NUM_WORDS);
    localparam int CNT_WORD  = NUM_STAGES + 1;
    localparam int REG_BASE  = NUM_STAGES + 2;

    logic [1:0]     rx_cnt;      // bytes of the current program word
    word_t          word_buf;
    logic           step_pulse;
    word_t          cycle_count;
    logic [WIW-1:0] word_idx;
    logic [1:0]     byte_cnt;
    logic           last_byte;
    word_t          dump_word;

    assign prog_data = word_buf;

    // core held in reset whenever it is not being run or dumped
    assign core_reset = (state == ST_WAITING) || (state == ST_IDLE)
                     || (state == ST_PROGRAMMING);

    assign step_en = step_pulse || ((state == ST_CONTINUOUS) && !halted);

    assign last_byte = (word_idx == WIW'(NUM_WORDS - 1)) && (byte_cnt == 2'd3);

    ////////////////////////////////
    // byte assembly, lsb first
    ////////////////////////////////
    always_ff @(posedge clk) begin
        if (rx_valid && (state == ST_PROGRAMMING)) begin
            word_buf <= {rx_data, word_buf[31:8]};
        end
    end

    ////////////////////////////////
    // control FSM
    ////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state       <= ST_WAITING;
            rx_cnt      <= '0;
            prog_we     <= 1'b0;
            prog_addr   <= '0;
            step_pulse  <= 1'b0;
            cycle_count <= '0;
            word_idx    <= '0;
            byte_cnt    <= '0;
            tx_start    <= 1'b0;
        end else begin
            step_pulse <= 1'b0;
            if (step_en) begin
                cycle_count <= cycle_count + 32'd1;
            end

            case (state)
                ST_IDLE: begin
                    rx_cnt    <= '0;
                    prog_addr <= '0;
                    if (rx_valid && (rx_data == CMD_START)) begin
                        state <= ST_PROGRAMMING;
                    end
                end

                ST_PROGRAMMING: begin
                    if (rx_valid) begin
                        rx_cnt <= rx_cnt + 2'd1;
                        if (rx_cnt == 2'd3) begin
                            prog_we <= 1'b1; // write next cycle
                        end
                    end
                    if (prog_we) begin
                        prog_we   <= 1'b0;
                        prog_addr <= prog_addr + 1'b1;
                        if (prog_data[OPC_MSB:OPC_LSB] == OP_HALT) begin
                            state <= ST_WAITING;
                        end
                    end
                end

                ST_WAITING: begin
                    cycle_count <= '0;
                    if (rx_valid) begin
                        case (rx_data)
                            CMD_REPROGRAM:  state <= ST_IDLE;
                            CMD_CONTINUOUS: state <= ST_CONTINUOUS;
                            CMD_STEP_MODE:  state <= ST_STEP_MODE;
                            default: ; // anything else is dropped
                        endcase
                    end
                end

                ST_STEP_MODE: begin
                    if (rx_valid) begin
                        if (rx_data == CMD_STEP) begin
                            step_pulse <= 1'b1;
                            state      <= ST_SENDING;
                        end else if (rx_data == CMD_REPROGRAM) begin
                            state <= ST_IDLE;
                        end
                    end
                end

                ST_CONTINUOUS: begin
                    if (halted) begin
                        state <= ST_SENDING;
                    end
                end

                ST_SENDING: begin
                    if (!tx_start) begin
                        tx_start <= 1'b1;
                    end else if (tx_done) begin
                        tx_start <= 1'b0;
                        byte_cnt <= byte_cnt + 2'd1;
                        if (byte_cnt == 2'd3) begin
                            word_idx <= word_idx + 1'b1;
                        end
                        if (last_byte) begin
                            word_idx <= '0;
                            state    <= halted ? ST_WAITING : ST_STEP_MODE;
                        end
                    end
                end

                default: state <= ST_WAITING;
            endcase
        end
    end

    ////////////////////////////////
    // dump source select
    ////////////////////////////////
    always_comb begin
        dump_word = reg_data;
        reg_addr  = '0;
        if (word_idx == '0) begin
            dump_word = pc;
        end else if (word_idx == WIW'(CNT_WORD)) begin
            dump_word = cycle_count;
        end else if (word_idx >= WIW'(REG_BASE)) begin
            reg_addr = RAW'(word_idx - WIW'(REG_BASE));
        end
        for (int s = 0; s < NUM_STAGES; s++) begin
            if (word_idx == WIW'(s + 1)) begin
                dump_word = snapshots[s].valid ? snapshots[s].instr : '0; // bubble reads 0
            end
        end
    end

    assign tx_data = dump_word[8*byte_cnt +: 8];

endmodule

//--- retire_unit.sv
`timescale 1ns/1ns

module retire_unit
    import dbg_pkg::*;
#(
    parameter int NUM_REGS = 8
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        core_reset,
    input  logic                        step_en,
    input  stage_t                      retire_in,
    input  logic [$clog2(NUM_REGS)-1:0] reg_addr,
    output word_t                       reg_data,
    output logic                        halted
);

    localparam int RAW = $clog2(NUM_REGS);

    word_t      regs [NUM_REGS];
    logic [5:0] opcode;
    logic [4:0] rd;
    word_t      imm_ext;
    logic       rd_ok;
    logic       retire;

    ////////////////////////////////
    // decode
    ////////////////////////////////
    assign opcode  = retire_in.instr[OPC_MSB:OPC_LSB];
    assign rd      = retire_in.instr[RD_MSB:RD_LSB];
    assign imm_ext = {16'd0, retire_in.instr[IMM_MSB:IMM_LSB]}; // zero extended
    assign rd_ok   = (int'(rd) < NUM_REGS);
    assign retire  = step_en && retire_in.valid;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            halted <= 1'b0;
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (core_reset) begin
            halted <= 1'b0;
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (retire) begin
            case (opcode)
                OP_LOAD_IMM: begin
                    if (rd_ok) begin
                        regs[rd[RAW-1:0]] <= imm_ext;
                    end
                end
                OP_ADD_IMM: begin
                    if (rd_ok) begin
                        regs[rd[RAW-1:0]] <= regs[rd[RAW-1:0]] + imm_ext;
                    end
                end
                OP_HALT: halted <= 1'b1;
                default: ; // no-op
            endcase
        end
    end

    // read port for the dump
    assign reg_data = regs[reg_addr];

endmodule

//--- pipe_stage.sv
`timescale 1ns/1ns

module pipe_stage
    import dbg_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   core_reset,
    input  logic   step_en,
    input  stage_t stage_in,
    output stage_t stage_out
);

    // latch between two stages, moves only when the core is stepped
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            stage_out <= '0;
        end else if (core_reset) begin
            stage_out <= '0; // bubble
        end else if (step_en) begin
            stage_out <= stage_in;
        end
    end

endmodule

//--- instr_fetch.sv
`timescale 1ns/1ns

module instr_fetch
    import dbg_pkg::*;
#(
    parameter int PROG_DEPTH = 64
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          core_reset,
    input  logic                          step_en,
    input  logic                          prog_we,
    input  logic [$clog2(PROG_DEPTH)-1:0] prog_addr,
    input  word_t                         prog_data,
    output stage_t                        fetch_out,
    output word_t                         pc
);

    localparam int PAW = $clog2(PROG_DEPTH);

    word_t mem [PROG_DEPTH];
    word_t cur_word;
    logic  halt_issued;

    // program memory, written only by the loader
    always_ff @(posedge clk) begin
        if (prog_we) begin
            mem[prog_addr] <= prog_data;
        end
    end

    assign cur_word = mem[pc[PAW-1:0]];

    // stage 1 captures this on the same step_en that bumps pc
    assign fetch_out = '{valid: !halt_issued, instr: cur_word};

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc          <= '0;
            halt_issued <= 1'b0;
        end else if (core_reset) begin
            pc          <= '0;
            halt_issued <= 1'b0;
        end else if (step_en && !halt_issued) begin
            pc <= pc + 32'd1;
            if (cur_word[OPC_MSB:OPC_LSB] == OP_HALT) begin
                halt_issued <= 1'b1; // pc frozen from here on
            end
        end
    end

endmodule

//--- dbg_pkg.sv
package dbg_pkg;

    ////////////////////////////////
    // data words and pipeline payload
    ////////////////////////////////
    typedef logic [31:0] word_t;

    typedef struct packed {
        logic  valid;
        word_t instr;
    } stage_t;

    // instruction fields
    localparam int OPC_MSB = 31;
    localparam int OPC_LSB = 26;
    localparam int RD_MSB  = 25;
    localparam int RD_LSB  = 21;
    localparam int IMM_MSB = 15;
    localparam int IMM_LSB = 0;

    localparam logic [5:0] OP_LOAD_IMM = 6'd1;
    localparam logic [5:0] OP_ADD_IMM  = 6'd2;
    localparam logic [5:0] OP_HALT     = 6'h3f;

    ////////////////////////////////
    // host commands
    ////////////////////////////////
    localparam logic [7:0] CMD_START      = 8'd1;
    localparam logic [7:0] CMD_CONTINUOUS = 8'd2;
    localparam logic [7:0] CMD_STEP_MODE  = 8'd3;
    localparam logic [7:0] CMD_REPROGRAM  = 8'd5;
    localparam logic [7:0] CMD_STEP       = 8'd6;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_PROGRAMMING,
        ST_WAITING,
        ST_STEP_MODE,
        ST_CONTINUOUS,
        ST_SENDING
    } dbg_state_t;

endpackage
